// ==== include/cdec_config.svh ====
//--------------------------------------------------------------------------
// CDEC core configuration
// Data and address widths, register count and start address
//--------------------------------------------------------------------------
`ifndef CDEC_CONFIG_SVH
`define CDEC_CONFIG_SVH

`define CDEC_DATA_W	8	// One data byte
`define CDEC_ADDR_W	8	// 256-byte address space

`define CDEC_REG_N	4	// PC, A, B, C

`define CDEC_RESET_PC	0	// First fetch address

`endif

// ==== rtl/cdecPkg.sv ====
//--------------------------------------------------------------------------
// CDEC core types
// Data, address, register select, ALU command, flags and sequencer states
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

package cdecPkg;

	typedef logic [`CDEC_DATA_W-1:0] dataT;
	typedef logic [`CDEC_ADDR_W-1:0] addrT;

	// Register numbers as coded in the IR fields
	typedef enum logic [$clog2(`CDEC_REG_N)-1:0] {
		regPc,
		regA,
		regB,
		regC
	} regSelT;

	// Order follows IR bits 5-2 with bit 3 inverted
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluAdc = 4'd1,
		aluSub = 4'd2,
		aluSbb = 4'd3,
		aluAnd = 4'd4,
		aluOr  = 4'd5,
		aluMov = 4'd6,	// CMP slot in the two-operand group
		aluXor = 4'd7,
		aluInc = 4'd8,
		aluDec = 4'd9,
		aluShr = 4'd10,
		aluShl = 4'd11,
		aluNot = 4'd12
	} aluCmdT;

	typedef struct packed {
		logic sign;
		logic zero;
		logic carry;
	} flagsT;

	typedef enum logic [4:0] {
		init, fetchAddr, fetchIr, decode,
		mov, aluOp, unary, cmp,
		immInc, loadMem,
		ldx, stx, storeMem,
		push, push1,
		pop, pop1, pop2,
		skipImm	// Keep last, the state check relies on it
	} stateT;

endpackage

`default_nettype wire

// ==== rtl/cdecIfs.sv ====
//--------------------------------------------------------------------------
// CDEC internal interfaces
// Sequencer to datapath control, and core to APB requester memory requests
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

interface cdecCtrlIf;
	cdecPkg::aluCmdT aluCmd;
	cdecPkg::regSelT dstSel;	// Register written from the ALU
	cdecPkg::regSelT srcSel1;	// Read bus 1
	cdecPkg::regSelT srcSel2;	// Read bus 2
	logic weRegs;
	logic weIr;
	logic weMar;
	logic weFlags;
	logic memRead;	// Read bus 1 carries memory data
	cdecPkg::dataT ir;
	cdecPkg::flagsT flags;

	modport seq (output aluCmd, dstSel, srcSel1, srcSel2, weRegs, weIr, weMar,
		weFlags, memRead, input ir, flags);
	modport dp (input aluCmd, dstSel, srcSel1, srcSel2, weRegs, weIr, weMar,
		weFlags, memRead, output ir, flags);
endinterface

interface cdecMemIf;
	cdecPkg::addrT addr;	// MAR
	cdecPkg::dataT wdata;
	logic rd;	// Held until done
	logic wr;
	cdecPkg::dataT rdata;
	logic done;	// One cycle at transfer end

	modport req (output addr, wdata, rd, wr, input rdata, done);
	modport rsp (input addr, wdata, rd, wr, output rdata, done);
endinterface

`default_nettype wire

// ==== rtl/alu.sv ====
//--------------------------------------------------------------------------
// CDEC ALU with sign, zero and carry flags register
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module alu (
	input wire iClkMst,
	input wire Reset,
	input wire cdecPkg::aluCmdT cmd,
	input wire cdecPkg::dataT opA,	// Read bus 1
	input wire cdecPkg::dataT opB,	// Read bus 2
	input wire weFlags,
	output cdecPkg::dataT result,
	output cdecPkg::flagsT flags
);
	logic [`CDEC_DATA_W:0] wide;	// Carry out in the top bit

	always_comb begin
		case (cmd)
			cdecPkg::aluAdd: wide = {1'b0, opA} + {1'b0, opB};
			cdecPkg::aluAdc: wide = {1'b0, opA} + {1'b0, opB} + flags.carry;
			cdecPkg::aluSub: wide = {1'b0, opA} - {1'b0, opB};	// Top bit is borrow
			cdecPkg::aluSbb: wide = {1'b0, opA} - {1'b0, opB} - flags.carry;
			cdecPkg::aluAnd: wide = {1'b0, opA & opB};
			cdecPkg::aluOr: wide = {1'b0, opA | opB};
			cdecPkg::aluXor: wide = {1'b0, opA ^ opB};
			cdecPkg::aluInc: wide = {1'b0, opA} + 1'b1;
			cdecPkg::aluDec: wide = {1'b0, opA} - 1'b1;
			cdecPkg::aluShr: wide = {opA[0], 1'b0, opA[`CDEC_DATA_W-1:1]};
			cdecPkg::aluShl: wide = {opA, 1'b0};
			cdecPkg::aluNot: wide = {1'b0, ~opA};
			default: wide = {1'b0, opA};	// mov
		endcase
	end

	assign result = wide[`CDEC_DATA_W-1:0];

	always_ff @(posedge iClkMst or posedge Reset) begin
		if (Reset) begin
			flags <= '0;
		end else if (weFlags) begin
			flags.sign <= wide[`CDEC_DATA_W-1];
			flags.zero <= (result == '0);
			flags.carry <= wide[`CDEC_DATA_W];
		end
	end

	// Jcc decisions rely on flags surviving non-ALU instructions
	assert property (@(posedge iClkMst) disable iff (Reset)
		!weFlags |=> $stable(flags));

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
//--------------------------------------------------------------------------
// CDEC register file, PC A B C, one write port and two read ports
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module regFile (
	input wire iClkMst,
	input wire Reset,
	input wire we,
	input wire cdecPkg::regSelT dstSel,
	input wire cdecPkg::regSelT srcSel1,
	input wire cdecPkg::regSelT srcSel2,
	input wire cdecPkg::dataT wdata,
	output cdecPkg::dataT rdata1,
	output cdecPkg::dataT rdata2,
	output cdecPkg::dataT regA,
	output cdecPkg::dataT regB
);
	cdecPkg::dataT regs [`CDEC_REG_N];

	always_ff @(posedge iClkMst or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < `CDEC_REG_N; i++) begin
				regs[i] <= (i == cdecPkg::regPc) ? cdecPkg::dataT'(`CDEC_RESET_PC) : '0;
			end
		end else if (we) begin
			regs[dstSel] <= wdata;
		end
	end

	assign rdata1 = regs[srcSel1];
	assign rdata2 = regs[srcSel2];

	assign regA = regs[cdecPkg::regA];	// Former display outputs
	assign regB = regs[cdecPkg::regB];

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
//--------------------------------------------------------------------------
// CDEC datapath with bus selection, IR, MAR, ALU and register file
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module datapath (
	input wire iClkMst,
	input wire Reset,
	cdecCtrlIf.dp ctrl,
	cdecMemIf.req mem,
	output cdecPkg::dataT regA,
	output cdecPkg::dataT regB
);
	cdecPkg::dataT bus0;	// ALU result
	cdecPkg::dataT bus1;
	cdecPkg::dataT bus2;
	cdecPkg::dataT regRd1;
	cdecPkg::dataT irQ;
	cdecPkg::addrT marQ;

	regFile uRegFile (
		.iClkMst, .Reset,
		.we(ctrl.weRegs), .dstSel(ctrl.dstSel),
		.srcSel1(ctrl.srcSel1), .srcSel2(ctrl.srcSel2),
		.wdata(bus0), .rdata1(regRd1), .rdata2(bus2),
		.regA, .regB
	);

	alu uAlu (
		.iClkMst, .Reset,
		.cmd(ctrl.aluCmd), .opA(bus1), .opB(bus2),
		.weFlags(ctrl.weFlags), .result(bus0), .flags(ctrl.flags)
	);

	assign bus1 = ctrl.memRead ? mem.rdata : regRd1;

	always_ff @(posedge iClkMst or posedge Reset) begin
		if (Reset) begin
			irQ <= '0;
			marQ <= '0;
		end else begin
			if (ctrl.weIr) irQ <= bus0;
			if (ctrl.weMar) marQ <= cdecPkg::addrT'(bus0);
		end
	end

	assign ctrl.ir = irQ;
	assign mem.addr = marQ;
	assign mem.wdata = bus1;	// Store source is always on bus 1

endmodule

`default_nettype wire

// ==== rtl/sequencer.sv ====
//--------------------------------------------------------------------------
// CDEC sequencer
// Fetch, decode and execute FSM with the jump condition check
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module sequencer (
	input wire iClkMst,
	input wire Reset,
	cdecCtrlIf.seq ctrl,
	cdecMemIf.req mem
);
	cdecPkg::stateT stateQ;
	cdecPkg::stateT stateNext;
	logic jccTrue;
	cdecPkg::regSelT irDst;	// IR bits 1-0
	cdecPkg::regSelT irSrc;	// IR bits 3-2
	cdecPkg::aluCmdT irCmd;

	assign irDst = cdecPkg::regSelT'(ctrl.ir[1:0]);
	assign irSrc = cdecPkg::regSelT'(ctrl.ir[3:2]);
	assign irCmd = cdecPkg::aluCmdT'(ctrl.ir[5:2] ^ 4'b1000);

	always_comb begin
		case (ctrl.ir[4:2])
			3'b100: jccTrue = ctrl.flags.sign;	// s
			3'b011: jccTrue = ~ctrl.flags.sign;	// ns
			3'b010: jccTrue = ctrl.flags.zero;	// z
			3'b101: jccTrue = ~ctrl.flags.zero;	// nz
			3'b001: jccTrue = ctrl.flags.carry;	// c
			3'b110: jccTrue = ~ctrl.flags.carry;	// nc
			default: jccTrue = 1'b0;
		endcase
	end

	always_ff @(posedge iClkMst or posedge Reset) begin
		if (Reset) stateQ <= cdecPkg::init;
		else stateQ <= stateNext;
	end

	always_comb begin
		ctrl.aluCmd = cdecPkg::aluMov;
		ctrl.dstSel = irDst;
		ctrl.srcSel1 = cdecPkg::regPc;
		ctrl.srcSel2 = irDst;
		ctrl.weRegs = 1'b0;
		ctrl.weIr = 1'b0;
		ctrl.weMar = 1'b0;
		ctrl.weFlags = 1'b0;
		ctrl.memRead = 1'b0;
		mem.rd = 1'b0;
		mem.wr = 1'b0;
		stateNext = cdecPkg::fetchAddr;
		case (stateQ)
			cdecPkg::fetchAddr: begin
				ctrl.weMar = 1'b1;	// MAR = PC
				stateNext = cdecPkg::fetchIr;
			end
			cdecPkg::fetchIr: begin
				ctrl.memRead = 1'b1;
				mem.rd = 1'b1;
				ctrl.weIr = mem.done;
				stateNext = mem.done ? cdecPkg::decode : cdecPkg::fetchIr;
			end
			cdecPkg::decode: begin
				ctrl.aluCmd = cdecPkg::aluInc;	// MAR = ++PC
				ctrl.dstSel = cdecPkg::regPc;
				ctrl.weRegs = 1'b1;
				ctrl.weMar = 1'b1;
				case (ctrl.ir[7:5])
					3'b000: stateNext = cdecPkg::mov;
					3'b001: stateNext = (ctrl.ir[4:2] == 3'b110) ? cdecPkg::cmp : cdecPkg::aluOp;
					3'b010: stateNext = cdecPkg::unary;
					3'b100: stateNext = ctrl.ir[4] ? cdecPkg::ldx : cdecPkg::fetchAddr;
					3'b101: stateNext = ctrl.ir[4] ? cdecPkg::stx : cdecPkg::fetchAddr;
					3'b110: begin
						if (ctrl.ir[4:2] == 3'b100) stateNext = cdecPkg::pop;
						else if (ctrl.ir[4]) stateNext = cdecPkg::push;
						else if (ctrl.ir[1:0] == 2'b00) stateNext = cdecPkg::loadMem;	// JMP
						else stateNext = cdecPkg::immInc;	// MVI
					end
					3'b111: stateNext = jccTrue ? cdecPkg::loadMem : cdecPkg::skipImm;
					default: stateNext = cdecPkg::fetchAddr;	// Group 011 is a no-op
				endcase
			end
			cdecPkg::mov: begin
				ctrl.srcSel1 = irSrc;
				ctrl.weRegs = 1'b1;
			end
			cdecPkg::aluOp: begin	// A = A op reg
				ctrl.aluCmd = irCmd;
				ctrl.dstSel = cdecPkg::regA;
				ctrl.srcSel1 = cdecPkg::regA;
				ctrl.weRegs = 1'b1;
				ctrl.weFlags = 1'b1;
			end
			cdecPkg::unary: begin
				ctrl.aluCmd = irCmd;
				ctrl.srcSel1 = irDst;
				ctrl.weRegs = 1'b1;
				ctrl.weFlags = 1'b1;
			end
			cdecPkg::cmp: begin
				ctrl.aluCmd = cdecPkg::aluSub;	// Flags only
				ctrl.srcSel1 = cdecPkg::regA;
				ctrl.weFlags = 1'b1;
			end
			cdecPkg::immInc, cdecPkg::skipImm: begin
				ctrl.aluCmd = cdecPkg::aluInc;	// Step PC over the operand byte
				ctrl.dstSel = cdecPkg::regPc;
				ctrl.weRegs = 1'b1;
				if (stateQ == cdecPkg::immInc) stateNext = cdecPkg::loadMem;
			end
			cdecPkg::loadMem: begin
				ctrl.dstSel = (ctrl.ir[7:5] == 3'b111) ? cdecPkg::regPc : irDst;
				ctrl.memRead = 1'b1;
				mem.rd = 1'b1;
				ctrl.weRegs = mem.done;
				stateNext = mem.done ? cdecPkg::fetchAddr : cdecPkg::loadMem;
			end
			cdecPkg::ldx: begin
				ctrl.srcSel1 = irSrc;	// MAR = address reg
				ctrl.weMar = 1'b1;
				stateNext = cdecPkg::loadMem;
			end
			cdecPkg::stx: begin
				ctrl.srcSel1 = irDst;
				ctrl.weMar = 1'b1;
				stateNext = cdecPkg::storeMem;
			end
			cdecPkg::storeMem, cdecPkg::push1: begin
				ctrl.srcSel1 = irSrc;	// Write data
				mem.wr = 1'b1;
				stateNext = mem.done ? cdecPkg::fetchAddr : stateQ;
			end
			cdecPkg::push: begin
				ctrl.aluCmd = cdecPkg::aluDec;	// MAR = --C
				ctrl.dstSel = cdecPkg::regC;
				ctrl.srcSel1 = cdecPkg::regC;
				ctrl.weRegs = 1'b1;
				ctrl.weMar = 1'b1;
				stateNext = cdecPkg::push1;
			end
			cdecPkg::pop: begin
				ctrl.srcSel1 = cdecPkg::regC;
				ctrl.weMar = 1'b1;
				stateNext = cdecPkg::pop1;
			end
			cdecPkg::pop1: begin
				ctrl.memRead = 1'b1;
				mem.rd = 1'b1;
				ctrl.weRegs = mem.done;
				stateNext = mem.done ? cdecPkg::pop2 : cdecPkg::pop1;
			end
			cdecPkg::pop2: begin
				ctrl.aluCmd = cdecPkg::aluInc;	// ++C
				ctrl.dstSel = cdecPkg::regC;
				ctrl.srcSel1 = cdecPkg::regC;
				ctrl.weRegs = 1'b1;
			end
			default: stateNext = cdecPkg::fetchAddr;	// init
		endcase
	end

	assert property (@(posedge iClkMst) disable iff (Reset)
		!$isunknown(stateQ) && stateQ <= cdecPkg::skipImm);

	// The requester serves one direction per transfer
	assert property (@(posedge iClkMst) disable iff (Reset)
		!(mem.rd && mem.wr));

endmodule

`default_nettype wire

// ==== rtl/apbRequester.sv ====
//--------------------------------------------------------------------------
// APB requester, one core memory request per APB transfer
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module apbRequester (
	input wire iClkMst,
	input wire Reset,
	cdecMemIf.rsp mem,
	output cdecPkg::addrT pAddr,
	output logic pSel,
	output logic pEnable,
	output logic pWrite,
	output cdecPkg::dataT pWdata,
	input wire cdecPkg::dataT pRdata,
	input wire pReady
);
	typedef enum logic [1:0] {idle, setup, access} apbStateT;

	apbStateT stateQ;
	cdecPkg::dataT rdataQ;	// Last read byte
	logic start;

	assign start = (stateQ == idle) && (mem.rd || mem.wr);

	always_ff @(posedge iClkMst or posedge Reset) begin
		if (Reset) begin
			stateQ <= idle;
			pWrite <= 1'b0;
		end else begin
			case (stateQ)
				idle: if (start) stateQ <= setup;
				setup: stateQ <= access;
				access: if (pReady) stateQ <= idle;
				default: stateQ <= idle;
			endcase
			if (start) pWrite <= mem.wr;
			else if (mem.done) pWrite <= 1'b0;
		end
	end

	always_ff @(posedge iClkMst) begin
		if (start) begin
			pAddr <= mem.addr;
			pWdata <= mem.wdata;
		end
		if (mem.done) rdataQ <= pRdata;
	end

	assign pSel = (stateQ != idle);
	assign pEnable = (stateQ == access);
	assign mem.done = (stateQ == access) && pReady;
	assign mem.rdata = mem.done ? pRdata : rdataQ;	// Valid on the done cycle

	assert property (@(posedge iClkMst) disable iff (Reset)
		(pSel && !pReady) |=> $stable(pAddr) && $stable(pWrite) && $stable(pWdata));

endmodule

`default_nettype wire

// ==== rtl/cdecTop.sv ====
//--------------------------------------------------------------------------
// CDEC core top level
// Sequencer, datapath and APB requester behind plain ports
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module cdecTop (
	input wire iClkMst,
	input wire Reset,
	output cdecPkg::addrT pAddr,
	output logic pSel,
	output logic pEnable,
	output logic pWrite,
	output cdecPkg::dataT pWdata,
	input wire cdecPkg::dataT pRdata,
	input wire pReady,
	output cdecPkg::dataT regA,
	output cdecPkg::dataT regB
);
	cdecCtrlIf ctrlIf ();
	cdecMemIf memIf ();

	sequencer uSequencer (.iClkMst, .Reset, .ctrl(ctrlIf.seq), .mem(memIf.req));

	datapath uDatapath (.iClkMst, .Reset, .ctrl(ctrlIf.dp), .mem(memIf.req), .regA, .regB);

	apbRequester uApbRequester (
		.iClkMst, .Reset, .mem(memIf.rsp),
		.pAddr, .pSel, .pEnable, .pWrite, .pWdata, .pRdata, .pReady
	);

endmodule

`default_nettype wire

// ==== verification/cdecTb.sv ====
//--------------------------------------------------------------------------
// CDEC core testbench
// Acts as the APB memory and runs directed instruction tests
//--------------------------------------------------------------------------
`default_nettype none

`include "cdec_config.svh"

module cdecTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam cdecPkg::addrT Marker = 8'h20;	// Holds JMP to itself
	localparam int InstrSum = 1 + 6 + 2 * 13 * 8 + 6 + 7;
	localparam int RunCount = 30;
	localparam int WatchdogNs = (InstrSum * 12 * 4 + RunCount * 20) * 8;

	logic iClkMst = 1'b0;
	logic Reset;
	logic pSel, pEnable, pWrite, pReady;
	cdecPkg::addrT pAddr;
	cdecPkg::dataT pWdata, pRdata, regA, regB;

	cdecPkg::dataT mem [256];
	cdecPkg::addrT wrAddrQ [$];	// Completed writes
	cdecPkg::dataT wrDataQ [$];
	cdecPkg::addrT firstAddr;
	logic firstWrite, firstSeen, markerHit;
	logic forceWait = 1'b0;
	int waitLeft;
	logic [7:0] lfsr = 8'd12;
	cdecPkg::addrT loadPtr;
	int errors = 0;
	string testName = "none";

	// Drawn once and reused by the back-pressure pass
	cdecPkg::dataT opX [13], opY [13], opCin [13];
	logic [2:0] opCond [13];

	cdecTop UUT (.*);

	always #4 iClkMst = ~iClkMst;

	// Galois LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] takeBits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	// APB memory with 0 to 3 wait states per transfer
	always @(posedge iClkMst) begin
		if (Reset) begin
			pReady <= 1'b0;
			markerHit <= 1'b0;
			firstSeen <= 1'b0;
		end else if (pSel && !pEnable) begin	// Setup cycle
			waitLeft = forceWait ? 3 : int'(takeBits(2));
			pRdata <= mem[pAddr];
			pReady <= (waitLeft == 0);
		end else if (pSel && !pReady) begin
			waitLeft--;
			pReady <= (waitLeft == 0);
		end else if (pSel) begin	// Transfer ends on this edge
			pReady <= 1'b0;
			if (pWrite) begin
				mem[pAddr] = pWdata;
				wrAddrQ.push_back(pAddr);
				wrDataQ.push_back(pWdata);
			end else if (pAddr == Marker) begin
				markerHit <= 1'b1;
			end
			if (!firstSeen) begin
				firstSeen <= 1'b1;
				firstAddr <= pAddr;
				firstWrite <= pWrite;
			end
		end
	end

	task automatic checkData(input string name, input cdecPkg::dataT exp,
		input cdecPkg::dataT act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkAddr(input string name, input cdecPkg::addrT exp,
		input cdecPkg::addrT act);
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("%s", what);
	endtask

	// Ops 0-7 two-operand with 6 as CMP and 8-12 INC DEC SHR SHL NOT
	function automatic cdecPkg::dataT refAlu(input int op, input cdecPkg::dataT a,
		input cdecPkg::dataT b, input logic cin, output cdecPkg::flagsT f);
		int r;
		case (op)
			0: r = int'(a) + int'(b);
			1: r = int'(a) + int'(b) + int'(cin);
			2, 6: r = int'(a) - int'(b);
			3: r = int'(a) - int'(b) - int'(cin);
			4: r = int'(a & b);
			5: r = int'(a | b);
			7: r = int'(a ^ b);
			8: r = int'(a) + 1;
			9: r = int'(a) - 1;
			10: r = int'(a) / 2;
			11: r = int'(a) * 2;
			default: r = 255 - int'(a);
		endcase
		f.sign = r[7];
		f.zero = (r[7:0] == 8'd0);
		f.carry = (op == 10) ? a[0] : (r < 0 || r > 255);	// Borrow counts as carry
		return cdecPkg::dataT'(r);
	endfunction

	function automatic logic condTrue(input logic [2:0] cc, input cdecPkg::flagsT f);
		case (cc)
			3'b100: return f.sign;
			3'b011: return !f.sign;
			3'b010: return f.zero;
			3'b101: return !f.zero;
			3'b001: return f.carry;
			default: return !f.carry;
		endcase
	endfunction

	// Holds the core in reset and refills memory
	task automatic enterReset();
		@(posedge iClkMst);
		Reset <= 1'b1;
		repeat (16) @(posedge iClkMst);
		wrAddrQ.delete();
		wrDataQ.delete();
		for (int i = 0; i < 256; i++) begin
			mem[i] = cdecPkg::dataT'(i * 37 + 11);
		end
		mem[Marker] = 8'hC0;
		mem[Marker + 1] = Marker;
		loadPtr = '0;
	endtask

	// First byte of the program sits in the top bits
	task automatic loadBytes(input logic [127:0] bytes, input int n);
		for (int i = 0; i < n; i++) begin
			mem[loadPtr] = bytes[(n - 1 - i) * 8 +: 8];
			loadPtr++;
		end
	endtask

	task automatic runToMarker(input string name);
		testName = name;
		@(posedge iClkMst);
		Reset <= 1'b0;
		while (!markerHit) @(posedge iClkMst);
		@(negedge iClkMst);
	endtask

	task automatic resetTest();
		enterReset();
		@(negedge iClkMst);
		if (pSel !== 1'b0) reportFailure("pSel is high while reset is held");
		checkData("reset regA", 8'h00, regA);
		checkData("reset regB", 8'h00, regB);
		loadBytes({8'hC0, Marker}, 2);
		runToMarker("reset");
		checkAddr("reset first address", cdecPkg::addrT'(`CDEC_RESET_PC), firstAddr);
		if (firstWrite !== 1'b0) reportFailure("first transfer after reset is a write");
	endtask

	task automatic mviMovTest();
		cdecPkg::dataT x, y;
		x = takeBits(8);
		y = takeBits(8);
		enterReset();
		// MVI A, MVI B, then swap through C
		loadBytes({8'hC1, x, 8'hC2, y, 8'h07, 8'h09, 8'h0E, 8'hC0, Marker}, 9);
		runToMarker("mvi mov");
		checkData("mvi mov regA", y, regA);
		checkData("mvi mov regB", x, regB);
	endtask

	task automatic aluTest(input logic stall);
		cdecPkg::flagsT f;
		cdecPkg::dataT res, expA, expB, opcode, jcc;
		logic cin;
		logic [2:0] condCodes [6];
		string name;
		condCodes = '{3'b100, 3'b011, 3'b010, 3'b101, 3'b001, 3'b110};
		forceWait = stall;
		for (int k = 0; k < 13; k++) begin
			if (!stall) begin
				opX[k] = takeBits(8);
				opY[k] = takeBits(8);
				opCin[k] = takeBits(8);
				opCond[k] = condCodes[takeBits(3) % 6];
			end
			void'(refAlu(11, opCin[k], 8'h00, 1'b0, f));	// SHL A sets the carry in
			cin = f.carry;
			res = refAlu(k, opX[k], opY[k], cin, f);
			expA = (k == 6) ? opX[k] : res;
			expB = condTrue(opCond[k], f) ? 8'h22 : 8'h11;
			if (k < 8) opcode = cdecPkg::dataT'(8'h22 | (k << 2));
			else opcode = cdecPkg::dataT'(8'h41 | ((k - 8) << 2));
			jcc = {3'b111, opCond[k], 2'b00};
			if (stall) name = $sformatf("stalled alu op %0d", k);
			else name = $sformatf("alu op %0d", k);
			enterReset();
			loadBytes({8'hC1, opCin[k], 8'h4D, 8'hC1, opX[k], 8'hC2, opY[k], opcode,
				jcc, 8'h10, 8'hC2, 8'h11, 8'hC0, Marker}, 14);
			loadPtr = 8'h10;	// Taken branch
			loadBytes({8'hC2, 8'h22, 8'hC0, Marker}, 4);
			runToMarker(name);
			checkData({name, " regA"}, expA, regA);
			checkData({name, " regB"}, expB, regB);
		end
		forceWait = 1'b0;
	endtask

	task automatic loadStoreTest();
		cdecPkg::dataT x;
		cdecPkg::addrT a;
		x = takeBits(8);
		a = 8'h40 | takeBits(6);	// Away from program and marker
		enterReset();
		// STX A to [C], clear A, LDX A from [C]
		loadBytes({8'hC1, x, 8'hC3, a, 8'hB7, 8'hC1, 8'h00, 8'h9D, 8'hC0, Marker}, 10);
		runToMarker("ldx stx");
		if (wrAddrQ.size() != 1) begin
			reportFailure($sformatf("ldx stx saw %0d write transfers, not one", wrAddrQ.size()));
		end else begin
			checkAddr("stx address", a, wrAddrQ[0]);
			checkData("stx data", x, wrDataQ[0]);
		end
		checkData("ldx regA", x, regA);
	endtask

	task automatic pushPopTest();
		cdecPkg::dataT x;
		cdecPkg::addrT sp;
		x = takeBits(8);
		sp = 8'h80 | takeBits(6);
		enterReset();
		// PUSH A, clear A, POP A, then MOV B from C
		loadBytes({8'hC3, sp, 8'hC1, x, 8'hD4, 8'hC1, 8'h00, 8'hD1, 8'h0E, 8'hC0, Marker}, 11);
		runToMarker("push pop");
		if (wrAddrQ.size() != 1) begin
			reportFailure($sformatf("push pop saw %0d write transfers, not one", wrAddrQ.size()));
		end else begin
			checkAddr("push address", cdecPkg::addrT'(sp - 8'd1), wrAddrQ[0]);
			checkData("push data", x, wrDataQ[0]);
		end
		checkData("pop regA", x, regA);
		checkData("stack pointer in regB", sp, regB);
	endtask

	initial begin
		Reset <= 1'b1;
		pRdata <= '0;
		pReady <= 1'b0;
		mviMovTest();
		resetTest();	// Registers and bus are busy before this reset
		aluTest(1'b0);
		loadStoreTest();
		pushPopTest();
		aluTest(1'b1);	// Three wait states on every transfer
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("Watchdog expired, test %s never fetched the marker", testName);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cdec.f ====
+incdir+include
rtl/cdecPkg.sv
rtl/cdecIfs.sv
rtl/alu.sv
rtl/regFile.sv
rtl/datapath.sv
rtl/sequencer.sv
rtl/apbRequester.sv
rtl/cdecTop.sv
verification/cdecTb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = cdecTb
FLIST = cdec.f
LOG   = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "Checks failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
